// File: rtl/cpuPkg.sv
// CPU package with widths, opcodes, ALU codes and pipeline register layouts
`default_nettype none

package cpuPkg;

    // ==============================
    // Widths and basic types
    // ==============================
    localparam int XLEN     = 32;
    localparam int RegAddrW = 5;
    // Word address width shared by both memory ports
    localparam int IAddrW   = 30;

    typedef logic [XLEN-1:0]     wordT;
    typedef logic [RegAddrW-1:0] regAddrT;

    // Opcode field taken from instruction bits 6 to 2
    localparam logic [4:0] OpRtype = 5'b01100;
    localparam logic [4:0] OpItype = 5'b00100;
    localparam logic [4:0] OpLoad  = 5'b00000;
    localparam logic [4:0] OpStore = 5'b01000;

    // addi x0, x0, 0
    localparam wordT Nop = 32'h0000_0013;

    typedef enum logic [3:0] {
        AluAdd = 4'd0,
        AluSub,
        AluSlt,
        AluXor,
        AluOr,
        AluAnd,
        AluSll,
        AluSrl,
        AluSra
    } aluOpT;

    // ==============================
    // Pipeline registers
    // ==============================
    typedef struct packed {
        logic [IAddrW-1:0] pc;
        wordT              instr;
    } ifIdT;

    typedef struct packed {
        logic    valid;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    aluSrc;
        aluOpT   aluOp;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
        wordT    rs1Data;
        wordT    rs2Data;
        wordT    imm;
    } idExT;

    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        regAddrT rd;
        wordT    aluResult;
        wordT    storeData;
    } exMemT;

    // Writeback bus, also the register file write port
    typedef struct packed {
        logic    regWrite;
        regAddrT rd;
        wordT    data;
    } wbT;

    typedef struct packed {
        logic              ren;
        logic              wen;
        logic [IAddrW-1:0] addr;
        wordT              wdata;
    } dmemReqT;

endpackage

`default_nettype wire

// File: rtl/fetchStage.sv
// Fetch stage with program counter and IF/ID register
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter cpuPkg::wordT ResetPc = '0
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         stall,
    input  wire                         hazardStall,
    output logic [cpuPkg::IAddrW-1:0]   iAddr,
    input  wire cpuPkg::wordT           iRdata,
    output cpuPkg::ifIdT                ifId
);

    cpuPkg::wordT pc;

    // Byte PC, the port takes the word address
    assign iAddr = pc[cpuPkg::XLEN-1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= ResetPc;
            ifId.pc    <= '0;
            ifId.instr <= cpuPkg::Nop;
        end else if (!stall && !hazardStall) begin
            pc         <= pc + cpuPkg::wordT'(4);
            ifId.pc    <= pc[cpuPkg::XLEN-1:2];
            ifId.instr <= iRdata;
        end
    end

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
// Decode stage with control decode, immediates, load-use detection and ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  stall,
    input  wire cpuPkg::ifIdT    ifId,
    output cpuPkg::regAddrT      rs1Addr,
    output cpuPkg::regAddrT      rs2Addr,
    input  wire cpuPkg::wordT    rs1Data,
    input  wire cpuPkg::wordT    rs2Data,
    output logic                 hazardStall,
    output cpuPkg::idExT         idEx
);

    cpuPkg::wordT instr;
    logic [4:0]   opcode;
    logic [2:0]   funct3;
    logic         legal;
    logic         useRs2;
    cpuPkg::idExT idExNext;

    // funct3 to ALU operation, alt picks sub or sra
    function automatic cpuPkg::aluOpT aluOpFor(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? cpuPkg::AluSub : cpuPkg::AluAdd;
            3'b001:  return cpuPkg::AluSll;
            3'b010:  return cpuPkg::AluSlt;
            3'b100:  return cpuPkg::AluXor;
            3'b101:  return alt ? cpuPkg::AluSra : cpuPkg::AluSrl;
            3'b110:  return cpuPkg::AluOr;
            3'b111:  return cpuPkg::AluAnd;
            default: return cpuPkg::AluAdd;
        endcase
    endfunction

    assign instr   = ifId.instr;
    assign opcode  = instr[6:2];
    assign funct3  = instr[14:12];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];

    // ==============================
    // Control and immediate decode
    // ==============================
    always_comb begin
        legal            = 1'b0;
        useRs2           = 1'b0;
        idExNext         = '0;
        idExNext.rs1     = rs1Addr;
        idExNext.rs2     = rs2Addr;
        idExNext.rd      = instr[11:7];
        idExNext.rs1Data = rs1Data;
        idExNext.rs2Data = rs2Data;
        idExNext.aluOp   = cpuPkg::AluAdd;
        // I-type layout unless a store overrides it
        idExNext.imm     = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            cpuPkg::OpRtype: begin
                // sltu is not supported
                legal             = (funct3 != 3'b011);
                useRs2            = 1'b1;
                idExNext.regWrite = 1'b1;
                idExNext.aluOp    = aluOpFor(funct3, instr[30]);
            end
            cpuPkg::OpItype: begin
                legal             = (funct3 != 3'b011);
                idExNext.regWrite = 1'b1;
                idExNext.aluSrc   = 1'b1;
                // Bit 30 only means sra for the right-shift group
                idExNext.aluOp    = aluOpFor(funct3, instr[30] && funct3 == 3'b101);
            end
            cpuPkg::OpLoad: begin
                legal             = 1'b1;
                idExNext.regWrite = 1'b1;
                idExNext.memRead  = 1'b1;
                idExNext.aluSrc   = 1'b1;
            end
            cpuPkg::OpStore: begin
                legal             = 1'b1;
                useRs2            = 1'b1;
                idExNext.memWrite = 1'b1;
                idExNext.aluSrc   = 1'b1;
                idExNext.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        // Anything else travels as a bubble
        idExNext.valid = legal;
        if (!legal) begin
            idExNext.regWrite = 1'b0;
            idExNext.memRead  = 1'b0;
            idExNext.memWrite = 1'b0;
        end
    end

    // Load in EX whose result is needed right now
    assign hazardStall = legal && idEx.memRead && idEx.rd != '0 &&
                         (idEx.rd == rs1Addr || (useRs2 && idEx.rd == rs2Addr));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx.valid    <= 1'b0;
            idEx.regWrite <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
        end else if (!stall) begin
            idEx <= idExNext;
            if (hazardStall) begin
                idEx.valid    <= 1'b0;
                idEx.regWrite <= 1'b0;
                idEx.memRead  <= 1'b0;
                idEx.memWrite <= 1'b0;
            end
        end
    end

    // The bubble clears the load, so the hazard lasts one free cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        hazardStall && !stall |=> !hazardStall)
        else $error("load-use stall held for two cycles");

endmodule

`default_nettype wire

// File: rtl/regFile.sv
// Register file with 31 writable registers, two write-through read ports and x0 at zero
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire cpuPkg::wbT        wb,
    input  wire cpuPkg::regAddrT   rs1Addr,
    input  wire cpuPkg::regAddrT   rs2Addr,
    output cpuPkg::wordT           rs1Data,
    output cpuPkg::wordT           rs2Data
);

    // x0 keeps its reset value
    cpuPkg::wordT regs [0:31];

    // Same-cycle write is visible to the reader
    function automatic cpuPkg::wordT readPort(input cpuPkg::regAddrT addr);
        if (wb.regWrite && wb.rd != '0 && wb.rd == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1Data = readPort(rs1Addr);
        rs2Data = readPort(rs2Addr);
    end

    // A frozen writeback bus rewrites the same value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.regWrite && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (rs1Addr != '0 || rs1Data == '0) && (rs2Addr != '0 || rs2Data == '0))
        else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
// Execute stage with operand forwarding, ALU and EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  stall,
    input  wire cpuPkg::idExT    idEx,
    input  wire cpuPkg::wbT      wb,
    output cpuPkg::exMemT        exMem
);

    cpuPkg::wordT opA;
    cpuPkg::wordT rs2Fwd;
    cpuPkg::wordT opB;
    cpuPkg::wordT aluResult;
    logic [4:0]   shamt;

    // Youngest producer wins, x0 is never forwarded
    function automatic cpuPkg::wordT forward(input cpuPkg::regAddrT rs,
                                             input cpuPkg::wordT regVal);
        if (exMem.regWrite && exMem.rd != '0 && exMem.rd == rs) begin
            return exMem.aluResult;
        end
        if (wb.regWrite && wb.rd != '0 && wb.rd == rs) begin
            return wb.data;
        end
        return regVal;
    endfunction

    // ==============================
    // Operand selection
    // ==============================
    always_comb begin
        opA    = forward(idEx.rs1, idEx.rs1Data);
        rs2Fwd = forward(idEx.rs2, idEx.rs2Data);
        opB    = idEx.aluSrc ? idEx.imm : rs2Fwd;
    end

    assign shamt = opB[4:0];

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (idEx.aluOp)
            cpuPkg::AluAdd: aluResult = opA + opB;
            cpuPkg::AluSub: aluResult = opA - opB;
            cpuPkg::AluSlt: begin
                aluResult = {{(cpuPkg::XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            end
            cpuPkg::AluXor: aluResult = opA ^ opB;
            cpuPkg::AluOr:  aluResult = opA | opB;
            cpuPkg::AluAnd: aluResult = opA & opB;
            cpuPkg::AluSll: aluResult = opA << shamt;
            cpuPkg::AluSrl: aluResult = opA >> shamt;
            cpuPkg::AluSra: aluResult = $signed(opA) >>> shamt;
            default:        aluResult = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMem.regWrite <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
        end else if (!stall) begin
            exMem.regWrite  <= idEx.regWrite;
            exMem.memRead   <= idEx.memRead;
            exMem.memWrite  <= idEx.memWrite;
            exMem.rd        <= idEx.rd;
            exMem.aluResult <= aluResult;
            // Store data must see forwarded values too
            exMem.storeData <= rs2Fwd;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !(idEx.memRead && idEx.memWrite))
        else $error("decode issued a load and a store together");

    assert property (@(posedge clk) disable iff (!rst_n)
        idEx.valid |-> idEx.aluOp inside {[cpuPkg::AluAdd:cpuPkg::AluSra]})
        else $error("unknown ALU operation on a valid instruction");

endmodule

`default_nettype wire

// File: rtl/memWbStage.sv
// MEM/WB register with writeback value selection
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  stall,
    input  wire cpuPkg::exMemT   exMem,
    input  wire cpuPkg::wordT    dRdata,
    output cpuPkg::wbT           wb
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb.regWrite <= 1'b0;
        end else if (!stall) begin
            wb.regWrite <= exMem.regWrite;
            wb.rd       <= exMem.rd;
            // Load data arrives in the same cycle as the request
            wb.data     <= exMem.memRead ? dRdata : exMem.aluResult;
        end
    end

endmodule

`default_nettype wire

// File: rtl/riscvPipeline.sv
// Five-stage RISC-V integer pipeline top, joins stages, register file and memory ports
`timescale 1ns/1ps
`default_nettype none

module riscvPipeline #(
    parameter cpuPkg::wordT ResetPc = '0
) (
    input  wire                         clk,
    input  wire                         rst_n,
    // Instruction port
    output logic [cpuPkg::IAddrW-1:0]   iAddr,
    input  wire cpuPkg::wordT           iRdata,
    input  wire                         iStall,
    // Data port
    output cpuPkg::dmemReqT             dReq,
    input  wire cpuPkg::wordT           dRdata,
    input  wire                         dStall
);

    logic            stall;
    logic            hazardStall;
    cpuPkg::ifIdT    ifId;
    cpuPkg::idExT    idEx;
    cpuPkg::exMemT   exMem;
    cpuPkg::wbT      wb;
    cpuPkg::regAddrT rs1Addr;
    cpuPkg::regAddrT rs2Addr;
    cpuPkg::wordT    rs1Data;
    cpuPkg::wordT    rs2Data;

    // Either port stalling freezes the whole pipeline
    assign stall = iStall | dStall;

    assign dReq = '{ren:   exMem.memRead,
                    wen:   exMem.memWrite,
                    addr:  exMem.aluResult[cpuPkg::XLEN-1:2],
                    wdata: exMem.storeData};

    fetchStage #(
        .ResetPc(ResetPc)
    ) uFetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .hazardStall(hazardStall),
        .iAddr      (iAddr),
        .iRdata     (iRdata),
        .ifId       (ifId)
    );

    decodeStage uDecode (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .ifId       (ifId),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .hazardStall(hazardStall),
        .idEx       (idEx)
    );

    regFile uRegFile (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb     (wb),
        .rs1Addr(rs1Addr),
        .rs2Addr(rs2Addr),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    executeStage uExecute (
        .clk  (clk),
        .rst_n(rst_n),
        .stall(stall),
        .idEx (idEx),
        .wb   (wb),
        .exMem(exMem)
    );

    memWbStage uMemWb (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .exMem (exMem),
        .dRdata(dRdata),
        .wb    (wb)
    );

endmodule

`default_nettype wire

// File: testbench/refModel.svh
// Reference model for the pipeline tests with encoders, program builder and ISA run
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

typedef struct packed {
    logic [29:0] addr;
    logic [31:0] data;
} storeT;

// R ops as {alt, funct3}: add sub slt xor or and sll srl sra
localparam logic [35:0] ROps = {4'h0, 4'h8, 4'h2, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5, 4'hD};
// I ops in the same form: addi slti xori ori andi slli srli srai
localparam logic [31:0] IOps = {4'h0, 4'h2, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5, 4'hD};

logic [31:0] prog [0:ProgLen-1];
logic [31:0] refMem [0:DmemWords-1];
storeT       expStores [$];
int          progCount;
int          storeSlot;

// ==============================
// Encoders
// ==============================
function automatic logic [31:0] rType(input logic [3:0] sel, input int rd, input int rs1,
                                      input int rs2);
    return {1'b0, sel[3], 5'b0, 5'(rs2), 5'(rs1), sel[2:0], 5'(rd), 7'b0110011};
endfunction

function automatic logic [31:0] iType(input logic [2:0] f3, input logic [11:0] imm,
                                      input int rd, input int rs1);
    return {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
endfunction

function automatic logic [31:0] loadWord(input int rd, input int off);
    return {12'(off), 5'd0, 3'b010, 5'(rd), 7'b0000011};
endfunction

function automatic logic [31:0] storeWord(input int rs2, input int off);
    logic [11:0] o;
    o = 12'(off);
    return {o[11:5], 5'(rs2), 5'd0, 3'b010, o[4:0], 7'b0100011};
endfunction

// Power-up data memory contents, distinct per word
function automatic logic [31:0] fillWord(input int idx);
    return 32'hD000_0000 | (32'(idx) << 12) | 32'(idx * 7 + 1);
endfunction

function automatic void emit(input logic [31:0] word);
    prog[progCount] = word;
    progCount++;
endfunction

// Store into the next rotating slot, returns the byte offset
function automatic int storeToSlot(input int rs);
    int off;
    off = storeSlot * 4;
    emit(storeWord(rs, off));
    storeSlot = (storeSlot + 1) % DmemWords;
    return off;
endfunction

// ==============================
// Program builder
// ==============================
function automatic void buildProgram();
    logic [3:0]  sel;
    logic [11:0] imm;
    int          off;
    progCount = 0;
    storeSlot = 0;
    for (int i = 1; i <= 3; i++) begin
        emit(iType(3'b000, 12'($random(seed)), i, 0));
    end
    // Store right after each result, store data forwarded from EX/MEM
    for (int i = 0; i < 9; i++) begin
        sel = ROps[35 - 4 * i -: 4];
        emit(rType(sel, 4 + i, 1, 2));
        void'(storeToSlot(4 + i));
    end
    // Chain of immediates, each source two slots back
    for (int i = 0; i < 8; i++) begin
        sel = IOps[31 - 4 * i -: 4];
        imm = 12'($random(seed));
        if (sel[1:0] == 2'b01) begin
            imm = {1'b0, sel[3], 5'b0, imm[4:0]};
        end
        emit(iType(sel[2:0], imm, 13 + i, 12 + i));
        void'(storeToSlot(13 + i));
    end
    // Back-to-back dependencies
    emit(rType(4'h0, 21, 13, 14));
    emit(rType(4'h8, 22, 21, 1));
    emit(rType(4'h4, 23, 22, 21));
    void'(storeToSlot(22));
    void'(storeToSlot(23));
    // Load-use on ALU operands, then load of a fresh store feeding store data
    emit(loadWord(24, 0));
    emit(rType(4'h0, 25, 24, 24));
    off = storeToSlot(25);
    emit(loadWord(26, off));
    void'(storeToSlot(26));
    // Writes to x0 must vanish
    emit(iType(3'b000, 12'($random(seed)), 0, 1));
    emit(rType(4'h0, 0, 1, 2));
    void'(storeToSlot(0));
    while (progCount < ProgLen) begin
        emit(32'h0000_0013);
    end
endfunction

// ==============================
// Architectural model
// ==============================
function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic void runReference();
    logic [31:0] x [0:31];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic        alt;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    for (int i = 0; i < DmemWords; i++) begin
        refMem[i] = fillWord(i);
    end
    expStores.delete();
    for (int pc = 0; pc < ProgLen; pc++) begin
        w = prog[pc];
        a = x[w[19:15]];
        case (w[6:0])
            7'b0110011, 7'b0010011: begin
                // Bit 5 set means register operand
                b   = w[5] ? x[w[24:20]] : {{20{w[31]}}, w[31:20]};
                alt = w[30] && (w[5] || w[14:12] == 3'b101);
                x[w[11:7]] = aluRef(w[14:12], alt, a, b);
            end
            7'b0000011: begin
                ea = a + {{20{w[31]}}, w[31:20]};
                x[w[11:7]] = refMem[ea[5:2]];
            end
            7'b0100011: begin
                ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
                refMem[ea[5:2]] = x[w[24:20]];
                expStores.push_back('{ea[31:2], x[w[24:20]]});
            end
            default: ;
        endcase
        x[0] = '0;
    end
endfunction

`endif

// File: testbench/tbRiscvPipeline.sv
// Testbench for the pipeline with stalling memories, store checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module tbRiscvPipeline;

    localparam int ProgLen     = 64;
    localparam int DmemWords   = 16;
    localparam int ResetCycles = 5;
    localparam int HalfPeriod  = 20;
    localparam int DriveDelay  = 2;
    // Eight cycles per program word covers heavy stalling
    localparam int MaxCycles   = ProgLen * 8;

    logic                      clk;
    logic                      rst_n;
    logic [cpuPkg::IAddrW-1:0] iAddr;
    cpuPkg::wordT              iRdata;
    logic                      iStall;
    cpuPkg::dmemReqT           dReq;
    cpuPkg::wordT              dRdata;
    logic                      dStall;

    integer      seed;
    int          mismatches;
    int          failures;
    logic        heldTaken;
    logic [31:0] dmem [0:DmemWords-1];

    `include "refModel.svh"

    riscvPipeline #(
        .ResetPc(32'h0)
    ) UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .iAddr (iAddr),
        .iRdata(iRdata),
        .iStall(iStall),
        .dReq  (dReq),
        .dRdata(dRdata),
        .dStall(dStall)
    );

    // Instruction memory returns Nop past the program
    assign iRdata = (iAddr < ProgLen) ? prog[iAddr[5:0]] : 32'h0000_0013;
    // Load data only while ren is high
    assign dRdata = dReq.ren ? dmem[dReq.addr[3:0]] : 32'hBAAD_F00D;

    always #HalfPeriod clk = ~clk;

    // About one cycle in four stalls on each port
    always @(posedge clk) begin
        #DriveDelay;
        iStall = ($random(seed) & 3) == 0;
        dStall = ($random(seed) & 3) == 0;
    end

    task automatic expectIdle(input string when);
        assert (dReq.ren === 1'b0 && dReq.wen === 1'b0 && iAddr === '0)
            else begin
                $display("mismatch at %0t: memory request or iAddr not idle %s", $time, when);
                mismatches++;
            end
    endtask

    task automatic compareStore();
        storeT want;
        assert (expStores.size() != 0)
            else begin
                $display("Store to word %0d at %0t is extra, no store was left to expect",
                         dReq.addr, $time);
                failures++;
            end
        if (expStores.size() != 0) begin
            want = expStores.pop_front();
            assert (dReq.addr === want.addr && dReq.wdata === want.data)
                else begin
                    $display("mismatch at %0t: store word %0d data %h, expected word %0d data %h",
                             $time, dReq.addr, dReq.wdata, want.addr, want.data);
                    mismatches++;
                end
        end
        dmem[dReq.addr[3:0]] = dReq.wdata;
    endtask

    // ==============================
    // Data memory and store checker
    // ==============================
    // Store is taken at the next edge unless dStall is high
    always @(negedge clk) begin
        if (!rst_n) begin
            expectIdle("during reset");
            heldTaken = 1'b0;
            for (int i = 0; i < DmemWords; i++) begin
                dmem[i] = fillWord(i);
            end
        end else begin
            if (dReq.wen && !dStall && !heldTaken) begin
                compareStore();
            end
            // A frozen pipeline presents the same store again
            heldTaken = (iStall || dStall) && (heldTaken || (dReq.wen && !dStall));
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        iStall     = 1'b0;
        dStall     = 1'b0;
        seed       = 42629;
        mismatches = 0;
        failures   = 0;
        buildProgram();
        runReference();
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        rst_n = 1'b1;
        @(negedge clk);
        expectIdle("in the first cycle after reset");
        // Done once the last program word is four fetches behind
        wait (iAddr >= ProgLen + 4);
        @(negedge clk);
        #DriveDelay;
        assert (expStores.size() == 0)
            else begin
                $display("%0d expected stores never appeared on the data port",
                         expStores.size());
                failures++;
            end
        for (int i = 0; i < DmemWords; i++) begin
            assert (dmem[i] === refMem[i])
                else begin
                    $display("mismatch at %0t: data word %0d is %h, expected %h",
                             $time, i, dmem[i], refMem[i]);
                    mismatches++;
                end
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (ResetCycles + MaxCycles) @(posedge clk);
        $display("Watchdog expired, the program never ran to its end (iAddr %0d)", iAddr);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+testbench
rtl/cpuPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/regFile.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/riscvPipeline.sv
testbench/tbRiscvPipeline.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tbRiscvPipeline -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
